//--- idec_isa_pkg.sv
/*
  rv32 instruction encoding for the decode unit
  major opcodes, instruction field layout,
  fixed SYSTEM words and funct7 codes
*/
`default_nettype none

package idec_isa_pkg;

  localparam int INSTR_W = 32;
  localparam int OPC_W   = 7;
  localparam int F7_W    = 7;
  localparam int F3_W    = 3;
  localparam int REG_W   = 5;

  // major opcodes, post forms are the custom pulp encodings
  typedef enum logic [OPC_W-1:0] {
    OPCODE_LOAD       = 7'h03,
    OPCODE_LOAD_POST  = 7'h0b,
    OPCODE_OPIMM      = 7'h13,
    OPCODE_AUIPC      = 7'h17,
    OPCODE_STORE      = 7'h23,
    OPCODE_STORE_POST = 7'h2b,
    OPCODE_OP         = 7'h33,
    OPCODE_LUI        = 7'h37,
    OPCODE_BRANCH     = 7'h63,
    OPCODE_JALR       = 7'h67,
    OPCODE_JAL        = 7'h6f,
    OPCODE_SYSTEM     = 7'h73
  } opcode_e;

  // r-type view, the other formats reuse these bit positions
  typedef struct packed {
    logic [F7_W-1:0]  funct7;
    logic [REG_W-1:0] rs2;
    logic [REG_W-1:0] rs1;
    logic [F3_W-1:0]  funct3;
    logic [REG_W-1:0] rd;
    opcode_e          opcode;
  } instr_t;

  // SYSTEM words with funct3 of zero
  localparam logic [INSTR_W-1:0] SYS_ECALL  = 32'h0000_0073;
  localparam logic [INSTR_W-1:0] SYS_EBREAK = 32'h0010_0073;
  localparam logic [INSTR_W-1:0] SYS_ERET   = 32'h1000_0073;
  localparam logic [INSTR_W-1:0] SYS_WFI    = 32'h1020_0073;

  localparam logic [F7_W-1:0] FUNCT7_ALT = 7'b0100000; // sub, sra
  localparam logic [F7_W-1:0] FUNCT7_MUL = 7'b0000001; // m extension

endpackage

`default_nettype wire

//--- idec_ctrl_pkg.sv
/*
  decoded control bundle and its enums,
  per-decoder result, isa configuration struct,
  the all-inactive bundle and counter width
*/
`default_nettype none

package idec_ctrl_pkg;

  localparam int ILL_CNT_W = 16;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLTS, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA, OP_A_CURRPC, OP_A_ZIMM, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REGB, OP_B_REGC, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND} branch_e;
  typedef enum logic [1:0] {JT_JAL, JT_JALR, JT_COND} jt_sel_e;
  typedef enum logic [1:0] {DT_WORD, DT_HALF, DT_BYTE} data_type_e;
  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    logic       op_c_jt;         // operand c carries jump target
    branch_e    jump;
    jt_sel_e    jt_sel;
    logic       mult_en;
    logic       rf_mem_we;       // load write-back port
    logic       rf_alu_we;       // alu write-back port
    logic       rf_alu_waddr_rd; // 0 -> rs1 gets the post-increment address
    logic       rega_used;
    logic       regb_used;
    logic       regc_used;
    logic       data_req;
    logic       data_we;
    data_type_e data_type;
    logic       data_sext;
    logic       prepost_useincr; // 0 -> bypass adder for address
    logic       csr_access;
    csr_op_e    csr_op;
    logic       trap;
    logic       eret;
    logic       pipe_flush;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    logic      hit; // decoder owns this opcode
    dec_ctrl_t ctrl;
  } dec_part_t;

  typedef struct packed {
    logic mul_en;
    logic postinc_en;
  } isa_cfg_t;

  localparam dec_ctrl_t CTRL_DEFAULT = '{
    alu_op:          ALU_NOP,
    op_a_sel:        OP_A_REGA,
    op_b_sel:        OP_B_REGB,
    imm_sel:         IMM_I,
    op_c_jt:         1'b0,
    jump:            BRANCH_NONE,
    jt_sel:          JT_JAL,
    mult_en:         1'b0,
    rf_mem_we:       1'b0,
    rf_alu_we:       1'b0,
    rf_alu_waddr_rd: 1'b1,
    rega_used:       1'b0,
    regb_used:       1'b0,
    regc_used:       1'b0,
    data_req:        1'b0,
    data_we:         1'b0,
    data_type:       DT_WORD,
    data_sext:       1'b0,
    prepost_useincr: 1'b1,
    csr_access:      1'b0,
    csr_op:          CSR_OP_NONE,
    trap:            1'b0,
    eret:            1'b0,
    pipe_flush:      1'b0,
    illegal:         1'b0
  };

endpackage

`default_nettype wire

//--- idec_flow_dec.sv
/*
  control flow decoder
  JAL, JALR and conditional branches
*/
`timescale 1ns/1ps
`default_nettype none

module idec_flow_dec (
  input  wire idec_isa_pkg::instr_t     instr_i,
  output idec_ctrl_pkg::dec_part_t      part_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  always_comb begin
    part_o.hit  = 1'b1;
    part_o.ctrl = CTRL_DEFAULT;

    case (instr_i.opcode)
      OPCODE_JAL, OPCODE_JALR: begin
        // link value pc+4 through the alu
        part_o.ctrl.op_a_sel  = OP_A_CURRPC;
        part_o.ctrl.op_b_sel  = OP_B_IMM;
        part_o.ctrl.imm_sel   = IMM_PCINCR;
        part_o.ctrl.alu_op    = ALU_ADD;
        part_o.ctrl.rf_alu_we = 1'b1;
        part_o.ctrl.op_c_jt   = 1'b1; // target from separate adder
        if (instr_i.opcode == OPCODE_JAL) begin
          part_o.ctrl.jump   = BRANCH_JAL;
          part_o.ctrl.jt_sel = JT_JAL;
        end else begin
          part_o.ctrl.jump      = BRANCH_JALR;
          part_o.ctrl.jt_sel    = JT_JALR;
          part_o.ctrl.rega_used = 1'b1; // rs1 + i imm
          if (instr_i.funct3 != 3'b000) begin
            // reserved funct3 behaves as a nop, no trap
            part_o.ctrl.jump      = BRANCH_NONE;
            part_o.ctrl.rf_alu_we = 1'b0;
          end
        end
      end

      OPCODE_BRANCH: begin
        part_o.ctrl.jump      = BRANCH_COND;
        part_o.ctrl.jt_sel    = JT_COND;
        part_o.ctrl.op_c_jt   = 1'b1;
        part_o.ctrl.rega_used = 1'b1;
        part_o.ctrl.regb_used = 1'b1;
        case (instr_i.funct3)
          3'b000:  part_o.ctrl.alu_op  = ALU_EQ;
          3'b001:  part_o.ctrl.alu_op  = ALU_NE;
          3'b100:  part_o.ctrl.alu_op  = ALU_LTS;
          3'b101:  part_o.ctrl.alu_op  = ALU_GES;
          3'b110:  part_o.ctrl.alu_op  = ALU_LTU;
          3'b111:  part_o.ctrl.alu_op  = ALU_GEU;
          default: part_o.ctrl.illegal = 1'b1; // 010, 011
        endcase
      end

      default: part_o.hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- idec_mem_dec.sv
/*
  load/store decoder
  immediate, register-offset and post-increment forms
  post-increment gated by the isa configuration
*/
`timescale 1ns/1ps
`default_nettype none

module idec_mem_dec (
  input  wire idec_isa_pkg::instr_t     instr_i,
  input  wire idec_ctrl_pkg::isa_cfg_t  cfg_i,
  output idec_ctrl_pkg::dec_part_t      part_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  logic is_post;

  assign is_post = (instr_i.opcode == OPCODE_LOAD_POST) ||
                   (instr_i.opcode == OPCODE_STORE_POST);

  always_comb begin
    part_o.hit  = 1'b1;
    part_o.ctrl = CTRL_DEFAULT;
    part_o.ctrl.alu_op = ALU_ADD; // address = rs1 + offset

    // write the updated address back to rs1
    if (is_post) begin
      part_o.ctrl.prepost_useincr = 1'b0;
      part_o.ctrl.rf_alu_waddr_rd = 1'b0;
      part_o.ctrl.rf_alu_we       = 1'b1;
    end

    case (instr_i.opcode)
      ////////////////////////////////
      // stores
      ////////////////////////////////
      OPCODE_STORE, OPCODE_STORE_POST: begin
        part_o.ctrl.data_req  = 1'b1;
        part_o.ctrl.data_we   = 1'b1;
        part_o.ctrl.rega_used = 1'b1;
        part_o.ctrl.regb_used = 1'b1; // store data
        if (instr_i.funct3[2]) begin
          part_o.ctrl.regc_used = 1'b1; // offset in rs3
          part_o.ctrl.op_b_sel  = OP_B_REGC;
        end else begin
          part_o.ctrl.imm_sel  = IMM_S;
          part_o.ctrl.op_b_sel = OP_B_IMM;
        end
        case (instr_i.funct3[1:0])
          2'b00: part_o.ctrl.data_type = DT_BYTE;
          2'b01: part_o.ctrl.data_type = DT_HALF;
          2'b10: part_o.ctrl.data_type = DT_WORD;
          default: begin
            part_o.ctrl.data_req = 1'b0;
            part_o.ctrl.data_we  = 1'b0;
            part_o.ctrl.illegal  = 1'b1;
          end
        endcase
      end

      ////////////////////////////////
      // loads
      ////////////////////////////////
      OPCODE_LOAD, OPCODE_LOAD_POST: begin
        part_o.ctrl.data_req  = 1'b1;
        part_o.ctrl.rf_mem_we = 1'b1;
        part_o.ctrl.rega_used = 1'b1;
        part_o.ctrl.op_b_sel  = OP_B_IMM;
        part_o.ctrl.data_sext = ~instr_i.funct3[2]; // lbu/lhu zero-extend
        case (instr_i.funct3[1:0])
          2'b00:   part_o.ctrl.data_type = DT_BYTE;
          2'b01:   part_o.ctrl.data_type = DT_HALF;
          default: part_o.ctrl.data_type = DT_WORD;
        endcase

        if (instr_i.funct3 == 3'b111) begin
          // reg-reg load, size and sign live in funct7
          part_o.ctrl.regb_used = 1'b1;
          part_o.ctrl.op_b_sel  = OP_B_REGB;
          part_o.ctrl.data_sext = ~instr_i.funct7[5];
          case (instr_i.funct7)
            7'b0000000, 7'b0100000: part_o.ctrl.data_type = DT_BYTE;
            7'b0001000, 7'b0101000: part_o.ctrl.data_type = DT_HALF;
            7'b0010000:             part_o.ctrl.data_type = DT_WORD;
            default:                part_o.ctrl.illegal   = 1'b1;
          endcase
        end

        if (instr_i.funct3 == 3'b011 || instr_i.funct3 == 3'b110) begin
          part_o.ctrl.illegal = 1'b1; // ld, lwu are rv64 only
        end

        if (part_o.ctrl.illegal) begin
          part_o.ctrl.data_req  = 1'b0;
          part_o.ctrl.rf_mem_we = 1'b0;
          part_o.ctrl.rf_alu_we = 1'b0;
        end
      end

      default: part_o.hit = 1'b0;
    endcase

    if (is_post && !cfg_i.postinc_en) part_o.ctrl.illegal = 1'b1; // extension off
  end

endmodule

`default_nettype wire

//--- idec_alu_dec.sv
/*
  integer alu decoder
  LUI, AUIPC, OP-IMM and OP with MUL
*/
`timescale 1ns/1ps
`default_nettype none

module idec_alu_dec (
  input  wire idec_isa_pkg::instr_t     instr_i,
  input  wire idec_ctrl_pkg::isa_cfg_t  cfg_i,
  output idec_ctrl_pkg::dec_part_t      part_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  always_comb begin
    part_o.hit  = 1'b1;
    part_o.ctrl = CTRL_DEFAULT;
    part_o.ctrl.rf_alu_we = 1'b1; // every form here writes rd

    case (instr_i.opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin
        part_o.ctrl.op_a_sel = (instr_i.opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        part_o.ctrl.op_b_sel = OP_B_IMM;
        part_o.ctrl.imm_sel  = IMM_U;
        part_o.ctrl.alu_op   = ALU_ADD;
      end

      OPCODE_OPIMM: begin
        part_o.ctrl.op_b_sel  = OP_B_IMM;
        part_o.ctrl.rega_used = 1'b1;
        case (instr_i.funct3)
          3'b000: part_o.ctrl.alu_op = ALU_ADD;
          3'b010: part_o.ctrl.alu_op = ALU_SLTS;
          3'b011: part_o.ctrl.alu_op = ALU_SLTU;
          3'b100: part_o.ctrl.alu_op = ALU_XOR;
          3'b110: part_o.ctrl.alu_op = ALU_OR;
          3'b111: part_o.ctrl.alu_op = ALU_AND;
          3'b001: begin
            part_o.ctrl.alu_op = ALU_SLL;
            if (instr_i.funct7 != 7'b0) part_o.ctrl.illegal = 1'b1;
          end
          default: begin // 101, srli or srai
            if (instr_i.funct7 == 7'b0) begin
              part_o.ctrl.alu_op = ALU_SRL;
            end else if (instr_i.funct7 == FUNCT7_ALT) begin
              part_o.ctrl.alu_op = ALU_SRA;
            end else begin
              part_o.ctrl.illegal = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        part_o.ctrl.rega_used = 1'b1;
        part_o.ctrl.regb_used = 1'b1;
        case ({instr_i.funct7, instr_i.funct3})
          {7'b0, 3'b000}:       part_o.ctrl.alu_op = ALU_ADD;
          {FUNCT7_ALT, 3'b000}: part_o.ctrl.alu_op = ALU_SUB;
          {7'b0, 3'b001}:       part_o.ctrl.alu_op = ALU_SLL;
          {7'b0, 3'b010}:       part_o.ctrl.alu_op = ALU_SLTS;
          {7'b0, 3'b011}:       part_o.ctrl.alu_op = ALU_SLTU;
          {7'b0, 3'b100}:       part_o.ctrl.alu_op = ALU_XOR;
          {7'b0, 3'b101}:       part_o.ctrl.alu_op = ALU_SRL;
          {FUNCT7_ALT, 3'b101}: part_o.ctrl.alu_op = ALU_SRA;
          {7'b0, 3'b110}:       part_o.ctrl.alu_op = ALU_OR;
          {7'b0, 3'b111}:       part_o.ctrl.alu_op = ALU_AND;
          {FUNCT7_MUL, 3'b000}: begin
            part_o.ctrl.mult_en = 1'b1; // result from multiplier, alu idle
            if (!cfg_i.mul_en) part_o.ctrl.illegal = 1'b1;
          end
          default: begin
            part_o.ctrl.rf_alu_we = 1'b0;
            part_o.ctrl.illegal   = 1'b1;
          end
        endcase
      end

      default: begin
        part_o.hit            = 1'b0;
        part_o.ctrl.rf_alu_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- idec_sys_dec.sv
/*
  SYSTEM decoder
  ECALL, EBREAK, ERET, WFI and CSR read/modify
*/
`timescale 1ns/1ps
`default_nettype none

module idec_sys_dec (
  input  wire idec_isa_pkg::instr_t     instr_i,
  output idec_ctrl_pkg::dec_part_t      part_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  logic [INSTR_W-1:0] word; // flat view for the fixed words

  assign word = instr_i;

  always_comb begin
    part_o.hit  = (instr_i.opcode == OPCODE_SYSTEM);
    part_o.ctrl = CTRL_DEFAULT;

    if (part_o.hit) begin
      if (instr_i.funct3 == 3'b000) begin
        case (word)
          SYS_ECALL:  ;                            // handled by the controller
          SYS_EBREAK: part_o.ctrl.trap       = 1'b1; // debug trap
          SYS_ERET:   part_o.ctrl.eret       = 1'b1;
          SYS_WFI:    part_o.ctrl.pipe_flush = 1'b1;
          default:    part_o.ctrl.illegal    = 1'b1;
        endcase
      end else begin
        // csr address sits in the i immediate
        part_o.ctrl.csr_access = 1'b1;
        part_o.ctrl.rf_alu_we  = 1'b1;
        part_o.ctrl.op_b_sel   = OP_B_IMM;
        part_o.ctrl.imm_sel    = IMM_I;
        if (instr_i.funct3[2]) begin
          part_o.ctrl.op_a_sel = OP_A_ZIMM; // rs1 field as zimm
        end else begin
          part_o.ctrl.op_a_sel  = OP_A_REGA;
          part_o.ctrl.rega_used = 1'b1;
        end
        case (instr_i.funct3[1:0])
          2'b01:   part_o.ctrl.csr_op  = CSR_OP_WRITE;
          2'b10:   part_o.ctrl.csr_op  = CSR_OP_SET;
          2'b11:   part_o.ctrl.csr_op  = CSR_OP_CLEAR;
          default: part_o.ctrl.illegal = 1'b1;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- idec_isa_cfg.sv
/*
  isa configuration register
  extension enables and saturating illegal counter
*/
`timescale 1ns/1ps
`default_nettype none

module idec_isa_cfg (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             cfg_we_i,
  input  wire idec_ctrl_pkg::isa_cfg_t          cfg_wdata_i,
  output idec_ctrl_pkg::isa_cfg_t               cfg_o,
  input  wire logic                             ill_pulse_i,
  output logic [idec_ctrl_pkg::ILL_CNT_W-1:0]   ill_cnt_o
);
  import idec_ctrl_pkg::*;

  logic cnt_max;

  assign cnt_max = &ill_cnt_o; // stick at all ones

  always_ff @(posedge clk_i, negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_o     <= '0; // extensions off
      ill_cnt_o <= '0;
    end else begin
      if (cfg_we_i) cfg_o <= cfg_wdata_i;
      if (ill_pulse_i && !cnt_max) ill_cnt_o <= ill_cnt_o + 1'b1;
    end
  end

  // saturation holds across further illegal pulses
  a_cnt_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_max |=> cnt_max)
    else $error("illegal counter wrapped");

endmodule

`default_nettype wire

//--- idec_hs_stage.sv
/*
  four-phase req/ack stage
  instruction capture, decoder merge,
  registered control bundle and illegal pulse
*/
`timescale 1ns/1ps
`default_nettype none

module idec_hs_stage (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             req_i,
  input  wire logic [idec_isa_pkg::INSTR_W-1:0] instr_i,
  input  wire logic                             illegal_c_i,
  output logic                                  ack_o,
  output idec_ctrl_pkg::dec_ctrl_t              ctrl_o,
  output idec_isa_pkg::instr_t                  instr_o,
  input  wire idec_ctrl_pkg::dec_part_t         flow_i,
  input  wire idec_ctrl_pkg::dec_part_t         mem_i,
  input  wire idec_ctrl_pkg::dec_part_t         alu_i,
  input  wire idec_ctrl_pkg::dec_part_t         sys_i,
  output logic                                  ill_pulse_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  typedef enum logic [1:0] {IDLE, DECODE, HOLD} state_e;

  state_e    state_q, state_d;
  instr_t    instr_q;
  logic      illegal_c_q; // compressed expansion failed
  dec_ctrl_t merged;

  //////////////////////////////
  // handshake fsm
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = DECODE; // capture edge
      DECODE:  state_d = HOLD;              // bundle registered
      HOLD:    if (!req_i) state_d = IDLE;  // back-pressure while req high
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ack_o = (state_q == HOLD);

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      instr_q     <= instr_i;
      illegal_c_q <= illegal_c_i;
    end
  end

  assign instr_o = instr_q; // to all four decoders

  //////////////////////////////
  // merge and output register
  //////////////////////////////
  always_comb begin
    if (flow_i.hit) begin
      merged = flow_i.ctrl;
    end else if (mem_i.hit) begin
      merged = mem_i.ctrl;
    end else if (alu_i.hit) begin
      merged = alu_i.ctrl;
    end else if (sys_i.hit) begin
      merged = sys_i.ctrl;
    end else begin
      merged         = CTRL_DEFAULT; // unknown opcode
      merged.illegal = 1'b1;
    end
    merged.illegal = merged.illegal | illegal_c_q;
  end

  always_ff @(posedge clk_i, negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_o      <= CTRL_DEFAULT;
      ill_pulse_o <= 1'b0;
    end else begin
      ill_pulse_o <= 1'b0;
      if (state_q == DECODE) begin
        ctrl_o      <= merged;         // kept as decoded, no fields cleared
        ill_pulse_o <= merged.illegal; // single cycle, DECODE lasts one
      end
    end
  end

  // opcode ownership is disjoint across decoders
  a_one_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == DECODE) |-> $onehot0({flow_i.hit, mem_i.hit, alu_i.hit, sys_i.hit}))
    else $error("more than one decoder hit");

  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(ack_o) |-> !$past(req_i))
    else $error("ack dropped while req high");

  a_ctrl_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_o && $past(ack_o)) |-> $stable(ctrl_o))
    else $error("ctrl changed during ack");

endmodule

`default_nettype wire

//--- idec_top.sv
/*
  rv32 decode unit top level
  handshake stage, four decoders, isa configuration
*/
`timescale 1ns/1ps
`default_nettype none

module idec_top (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             req_i,
  input  wire logic [idec_isa_pkg::INSTR_W-1:0] instr_i,
  input  wire logic                             illegal_c_i,
  output logic                                  ack_o,
  output idec_ctrl_pkg::dec_ctrl_t              ctrl_o,
  input  wire logic                             cfg_we_i,
  input  wire idec_ctrl_pkg::isa_cfg_t          cfg_wdata_i,
  output idec_ctrl_pkg::isa_cfg_t               cfg_o,
  output logic [idec_ctrl_pkg::ILL_CNT_W-1:0]   ill_cnt_o
);
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  instr_t    instr;     // captured word
  dec_part_t flow_part;
  dec_part_t mem_part;
  dec_part_t alu_part;
  dec_part_t sys_part;
  logic      ill_pulse;

  idec_hs_stage u_hs_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .instr_i     (instr_i),
    .illegal_c_i (illegal_c_i),
    .ack_o       (ack_o),
    .ctrl_o      (ctrl_o),
    .instr_o     (instr),
    .flow_i      (flow_part),
    .mem_i       (mem_part),
    .alu_i       (alu_part),
    .sys_i       (sys_part),
    .ill_pulse_o (ill_pulse)
  );

  idec_flow_dec u_flow_dec (.instr_i(instr), .part_o(flow_part));

  idec_mem_dec u_mem_dec (.instr_i(instr), .cfg_i(cfg_o), .part_o(mem_part));

  idec_alu_dec u_alu_dec (.instr_i(instr), .cfg_i(cfg_o), .part_o(alu_part));

  idec_sys_dec u_sys_dec (.instr_i(instr), .part_o(sys_part));

  // enables steer mem and alu decoders
  idec_isa_cfg u_isa_cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg_o),
    .ill_pulse_i (ill_pulse),
    .ill_cnt_o   (ill_cnt_o)
  );

endmodule

`default_nettype wire

//--- tb_idec.sv
/*
  testbench for the rv32 decode unit
  golden-file vectors over the req/ack handshake,
  config writes, hold and back-pressure checks,
  illegal-instruction count against a model counter
*/
`timescale 1ns/1ps
`default_nettype none

module tb_idec;
  import idec_isa_pkg::*;
  import idec_ctrl_pkg::*;

  localparam int    HALF_PERIOD  = 10;  // 20 ns clock
  localparam int    RESET_CYCLES = 16;
  localparam int    ACK_TIMEOUT  = 20;  // per handshake phase
  localparam int    RISE_CYCLES  = 2;   // capture, then register
  localparam int    FALL_CYCLES  = 1;
  localparam int    HOLD_CYCLES  = 3;   // req kept high past ack
  localparam int    EXP_W        = 40;  // bundle as 10 hex digits
  localparam string GOLDEN_FILE  = "idec_golden.mem";

  // nop alu, waddr_rd and useincr set, all else clear
  localparam logic [EXP_W-1:0] RESET_CTRL = 40'h00_0001_0080;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 req;
  logic [INSTR_W-1:0]   instr;
  logic                 illegal_c;
  logic                 ack;
  dec_ctrl_t            ctrl;
  logic                 cfg_we;
  isa_cfg_t             cfg_wdata;
  isa_cfg_t             cfg;
  logic [ILL_CNT_W-1:0] ill_cnt;

  int                   tests;
  int                   failed;
  logic                 aborted;   // timeout or missing file
  logic [ILL_CNT_W-1:0] model_ill; // expected illegal count

  always #HALF_PERIOD clk = ~clk;

  idec_top UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .instr_i     (instr),
    .illegal_c_i (illegal_c),
    .ack_o       (ack),
    .ctrl_o      (ctrl),
    .cfg_we_i    (cfg_we),
    .cfg_wdata_i (cfg_wdata),
    .cfg_o       (cfg),
    .ill_cnt_o   (ill_cnt)
  );

  //////////////////////////////
  // checks and reporting
  //////////////////////////////
  function automatic logic [EXP_W-1:0] as_hex(input dec_ctrl_t c);
    as_hex = {3'b000, c}; // 37-bit bundle, top digit pads
  endfunction

  task automatic check_eq(input logic [EXP_W-1:0] got, input logic [EXP_W-1:0] want,
                          input string what, inout logic ok);
    assert (got === want) else begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, want);
      ok = 1'b0;
    end
  endtask

  task automatic check_cycles(input int got, input int want, input string what,
                              inout logic ok);
    assert (got == want) else begin
      $display("Error at time %0t: %s after %0d cycles, expected %0d",
               $time, what, got, want);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input logic ok);
    tests++;
    if (!ok) failed++;
    $display("test %0d %s: %s", tests, name, ok ? "ok" : "mismatch");
  endtask

  // polls on falling edges, gives up after ACK_TIMEOUT
  task automatic wait_ack(input logic level, output int cycles, output logic timed_out);
    cycles    = 0;
    timed_out = 1'b0;
    while (ack !== level && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles >= ACK_TIMEOUT && ack !== level) timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // transactions
  //////////////////////////////
  task automatic check_reset();
    logic ok;
    ok = 1'b1;
    check_eq({39'b0, ack}, 40'h0, "ack_o after reset", ok);
    check_eq(as_hex(ctrl), RESET_CTRL, "ctrl_o after reset", ok);
    check_eq({24'b0, ill_cnt}, 40'h0, "ill_cnt_o after reset", ok);
    check_eq({38'b0, cfg}, 40'h0, "cfg_o after reset", ok); // extensions off
    report_test("reset state", ok);
  endtask

  task automatic write_cfg(input logic [1:0] value, input logic [1:0] want, inout logic ok);
    cfg_we    = 1'b1;
    cfg_wdata = isa_cfg_t'(value);
    @(negedge clk);           // taken on the rising edge between
    cfg_we    = 1'b0;
    check_eq({38'b0, cfg}, {38'b0, want}, "cfg_o", ok);
  endtask

  task automatic run_instr(input logic [INSTR_W-1:0] word, input logic ill_c,
                           input logic [EXP_W-1:0] want, inout logic ok);
    int               cycles;
    logic             tmo;
    logic [EXP_W-1:0] held;
    instr     = word;
    illegal_c = ill_c;
    req       = 1'b1;
    wait_ack(1'b1, cycles, tmo);
    if (tmo) begin
      $display("timeout: ack_o never rose for instruction %h", word);
      ok      = 1'b0;
      aborted = 1'b1;
    end else begin
      check_cycles(cycles, RISE_CYCLES, "ack_o rise", ok);
      held = as_hex(ctrl);
      check_eq(held, want, "ctrl_o", ok);
      // new word on the bus, must be ignored
      instr     = ~word;
      illegal_c = ~ill_c;
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        check_eq({39'b0, ack}, 40'h1, "ack_o during hold", ok);
        check_eq(as_hex(ctrl), held, "ctrl_o during hold", ok);
      end
      req = 1'b0;              // phase 3
      wait_ack(1'b0, cycles, tmo);
      if (tmo) begin
        $display("timeout: ack_o stayed high after req_i fell, instruction %h", word);
        ok      = 1'b0;
        aborted = 1'b1;
      end else begin
        check_cycles(cycles, FALL_CYCLES, "ack_o fall", ok);
        @(negedge clk); // idle gap before next req
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin : stimulus
    int                 fd;
    string              line;
    logic [7:0]         cmd;
    logic [INSTR_W-1:0] value;
    logic [3:0]         ill_c;
    logic [EXP_W-1:0]   want;
    logic               ok;

    rst_n     = 1'b0;
    req       = 1'b0;
    instr     = '0;
    illegal_c = 1'b0;
    cfg_we    = 1'b0;
    cfg_wdata = '0;
    tests     = 0;
    failed    = 0;
    aborted   = 1'b0;
    model_ill = '0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset();

    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", GOLDEN_FILE);
      aborted = 1'b1;
    end

    while (!aborted && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        // comment and blank lines give fewer than four items
        if ($sscanf(line, "%c %h %h %h", cmd, value, ill_c, want) == 4) begin
          ok = 1'b1;
          if (cmd == "C") begin
            write_cfg(value[1:0], want[1:0], ok);
          end else if (cmd == "I") begin
            if (want[0]) model_ill = model_ill + 1'b1; // illegal bit
            run_instr(value, ill_c[0], want, ok);
          end else begin
            $display("unknown command %c in the vector file", cmd);
            ok = 1'b0;
          end
          report_test($sformatf("%c %h", cmd, value), ok);
        end
      end
    end
    if (fd != 0) $fclose(fd);

    if (!aborted) begin
      ok = 1'b1;
      @(negedge clk); // last pulse has reached the counter
      check_eq({24'b0, ill_cnt}, {24'b0, model_ill}, "ill_cnt_o", ok);
      report_test("illegal count", ok);
    end

    $display("%0d tests run, %0d failed", tests, failed);
    if (failed == 0 && !aborted) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- idec_golden.mem
// cmd value illegal_c expected: C writes {mul_en, postinc_en} and expects cfg_o,
// I sends an instruction word and expects ctrl_o as 10 hex digits (alu_op in the top two)
I 000000ef 0 0167430080 // jal
I 000100e7 0 0167938080 // jalr
I 000110e7 0 0167118080 // jalr funct3 1, no jump no write
I 00310063 0 0b01e1c080 // beq
I 00311063 0 0c01e1c080 // bne
I 00314063 0 0d01e1c080 // blt
I 00315063 0 0e01e1c080 // bge
I 00316063 0 0f01e1c080 // bltu
I 00317063 0 1001e1c080 // bgeu
I 00312063 0 0001e1c081 // branch funct3 2
I 00010083 0 0120059580 // lb
I 00011083 0 0120059380 // lh
I 00012083 0 0120059180 // lw
I 00014083 0 0120059480 // lbu
I 00015083 0 0120059280 // lhu
I 00013083 0 0120018181 // load funct3 011
I 00016083 0 0120018081 // load funct3 110
I 00317083 0 010005d580 // lb reg offset
I 40317083 0 010005d480 // lbu reg offset
I 10317083 0 010005d380 // lh reg offset
I 50317083 0 010005d280 // lhu reg offset
I 20317083 0 010005d180 // lw reg offset
I 02317083 0 010001c181 // reg offset, unknown funct7
I 00310023 0 012201dc80 // sb
I 00311023 0 012201da80 // sh
I 00312023 0 012201d880 // sw
I 00313023 0 012201c081 // store width 3
I 00316023 0 011001f880 // sw reg offset
I 0001208b 0 0120069101 // lw post, extension off
I 0031202b 0 012202d801 // sw post, extension off
I 023100b3 0 00000bc081 // mul, extension off
C 00000003 0 0000000003 // enable mul and post-increment
I 0001208b 0 0120069100 // lw post
I 0031202b 0 012202d800 // sw post
I 023100b3 0 00000bc080 // mul
I 123450b7 0 01e4030080 // lui
I 12345097 0 0164030080 // auipc
I 00010093 0 0120038080 // addi
I 00012093 0 0920038080 // slti
I 00013093 0 0a20038080 // sltiu
I 00014093 0 0320038080 // xori
I 00016093 0 0420038080 // ori
I 00017093 0 0520038080 // andi
I 00311093 0 0620038080 // slli
I 00315093 0 0720038080 // srli
I 40315093 0 0820038080 // srai
I 40311093 0 0620038081 // slli, funct7 not zero
I 02315093 0 0020038081 // srli, unknown funct7
I 003100b3 0 010003c080 // add
I 403100b3 0 020003c080 // sub
I 003110b3 0 060003c080 // sll
I 003120b3 0 090003c080 // slt
I 003130b3 0 0a0003c080 // sltu
I 003140b3 0 030003c080 // xor
I 003150b3 0 070003c080 // srl
I 403150b3 0 080003c080 // sra
I 003160b3 0 040003c080 // or
I 003170b3 0 050003c080 // and
I 403110b3 0 000001c081 // op, unknown funct7/funct3
I 00000073 0 0000010080 // ecall
I 00100073 0 0000010088 // ebreak
I 10000073 0 0000010084 // eret
I 10200073 0 0000010082 // wfi
I 00200073 0 0000010081 // system funct3 0, unknown word
I 300110f3 0 00200380d0 // csrrw
I 300120f3 0 00200380e0 // csrrs
I 300130f3 0 00200380f0 // csrrc
I 300150f3 0 00a00300d0 // csrrwi
I 300140f3 0 00a00300c1 // csr funct3 100
I 0000007f 0 0000010081 // unknown opcode
I 00010093 1 0120038081 // addi, compressed decode failed

//--- verilog.f
idec_isa_pkg.sv
idec_ctrl_pkg.sv
idec_flow_dec.sv
idec_mem_dec.sv
idec_alu_dec.sv
idec_sys_dec.sv
idec_isa_cfg.sv
idec_hs_stage.sv
idec_top.sv
tb_idec.sv

//--- Makefile
# Verilator build, run, lint and clean for the decode unit

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_idec
LINT_TOP  ?= idec_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# output goes to the terminal, the status comes from the search
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
